//--- hw/JZJCoreFTypes.sv
`default_nettype none

package JZJCoreFTypes;

	// Major opcodes handled by the control-flow slice
	typedef enum logic [6:0]
	{
		JALOP = 7'b1101111,
		JALROP = 7'b1100111,
		BRANCHOP = 7'b1100011
	} Opcode_t;

	typedef logic [2:0] Funct3_t; // Branch condition select

	// How the BranchALU picks the next PC
	typedef enum logic [1:0]
	{
		JAL,
		JALR,
		BRANCH,
		INCREMENT // Illegal instructions just step past
	} BranchALUMode_t;

	typedef struct packed
	{
		BranchALUMode_t branchALUMode;
		Funct3_t funct3;
		logic [4:0] rs1Index;
		logic [4:0] rs2Index;
		logic [4:0] rdIndex;
		logic writesRd; // Only jal/jalr with rd != x0
		logic illegal;
		logic [31:0] immediateJ;
		logic [31:0] immediateI;
		logic [31:0] immediateB;
	} DecodedInstr_t;

endpackage

`default_nettype wire

//--- hw/CoreStatePkg.sv
`default_nettype none

package CoreStatePkg;

	// One instruction in flight, one state per step
	typedef enum logic [1:0]
	{
		IDLE,
		DECODE,
		EXECUTE,
		RETIRE
	} CoreState_t;

	typedef struct packed
	{
		logic enable;
		logic [4:0] index;
		logic [31:0] data;
	} RegWrite_t;

	// Everything observable about one retired instruction
	typedef struct packed
	{
		logic [31:0] pc;
		logic [31:0] nextPc;
		logic [4:0] rdIndex;
		logic [31:0] rdValue; // Zero unless rdWritten
		logic rdWritten;
		logic taken;
		logic illegal;
	} RetireRecord_t;

endpackage

`default_nettype wire

//--- hw/InstructionDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module InstructionDecoder
(
	input logic [31:0] instruction,
	output JZJCoreFTypes::DecodedInstr_t decoded
);

JZJCoreFTypes::Opcode_t opcode;

assign opcode = JZJCoreFTypes::Opcode_t'(instruction[6:0]);

always_comb
begin
	// Fixed field positions, sliced regardless of format
	decoded.funct3 = instruction[14:12];
	decoded.rs1Index = instruction[19:15];
	decoded.rs2Index = instruction[24:20];
	decoded.rdIndex = instruction[11:7];

	// J immediate, bits scrambled per spec
	decoded.immediateJ = {{12{instruction[31]}}, instruction[19:12], instruction[20],
		instruction[30:21], 1'b0};
	decoded.immediateI = {{20{instruction[31]}}, instruction[31:20]};
	decoded.immediateB = {{20{instruction[31]}}, instruction[7], instruction[30:25],
		instruction[11:8], 1'b0}; // Always even

	// Defaults describe an illegal instruction
	decoded.branchALUMode = JZJCoreFTypes::INCREMENT;
	decoded.writesRd = 1'b0;
	decoded.illegal = 1'b0;

	case (opcode)
		JZJCoreFTypes::JALOP:
		begin
			decoded.branchALUMode = JZJCoreFTypes::JAL;
			decoded.writesRd = instruction[11:7] != 5'd0; // Link to x0 is discarded
		end
		JZJCoreFTypes::JALROP:
		begin
			if (instruction[14:12] != 3'b000)
				decoded.illegal = 1'b1; // jalr needs funct3 000
			else
			begin
				decoded.branchALUMode = JZJCoreFTypes::JALR;
				decoded.writesRd = instruction[11:7] != 5'd0;
			end
		end
		JZJCoreFTypes::BRANCHOP:
		begin
			if (instruction[14:13] == 2'b01)
				decoded.illegal = 1'b1; // 010 and 011 are unassigned
			else
				decoded.branchALUMode = JZJCoreFTypes::BRANCH;
		end
		default: decoded.illegal = 1'b1; // Not control flow
	endcase
end

endmodule

`default_nettype wire

//--- hw/BranchALU.sv
`timescale 1ns/1ps
`default_nettype none

module BranchALU
(
	input JZJCoreFTypes::BranchALUMode_t branchALUMode,
	input JZJCoreFTypes::Funct3_t funct3,

	input logic [31:0] immediateJ,
	input logic [31:0] immediateI,
	input logic [31:0] immediateB,

	input logic [31:0] rs1,
	input logic [31:0] rs2,
	input logic [31:0] pcOfInstruction,

	output logic [31:0] programCounterInput,
	output logic [31:0] branchALUOutput, // Link value
	output logic branchTaken // Condition result only
);

logic [31:0] nextSequentialPc;
logic [31:0] nextJalPc;
logic [31:0] jalrSum;
logic [31:0] nextJalrPc;
logic [31:0] nextBranchPc;

assign nextSequentialPc = pcOfInstruction + 32'd4;
assign nextJalPc = pcOfInstruction + immediateJ;
assign jalrSum = rs1 + immediateI;
assign nextJalrPc = {jalrSum[31:1], 1'b0}; // Spec clears bit 0
assign nextBranchPc = pcOfInstruction + immediateB;

// Only jal/jalr consume it, everyone else ignores it
assign branchALUOutput = nextSequentialPc;

always_comb
begin
	case (funct3)
		3'b000: branchTaken = rs1 == rs2; // beq
		3'b001: branchTaken = rs1 != rs2; // bne
		3'b100: branchTaken = $signed(rs1) < $signed(rs2); // blt
		3'b101: branchTaken = $signed(rs1) >= $signed(rs2); // bge
		3'b110: branchTaken = rs1 < rs2; // bltu
		3'b111: branchTaken = rs1 >= rs2; // bgeu
		default: branchTaken = 1'b0; // Decoder already flagged these illegal
	endcase
end

always_comb
begin
	unique case (branchALUMode)
		JZJCoreFTypes::JAL: programCounterInput = nextJalPc;
		JZJCoreFTypes::JALR: programCounterInput = nextJalrPc;
		JZJCoreFTypes::BRANCH:
			programCounterInput = branchTaken ? nextBranchPc : nextSequentialPc;
		JZJCoreFTypes::INCREMENT: programCounterInput = nextSequentialPc;
	endcase
end

endmodule

`default_nettype wire

//--- hw/RegisterFile.sv
`timescale 1ns/1ps
`default_nettype none

module RegisterFile
(
	input logic clock,
	input logic rstN,

	input logic [4:0] rs1Index,
	input logic [4:0] rs2Index,
	output logic [31:0] rs1Value,
	output logic [31:0] rs2Value,

	input CoreStatePkg::RegWrite_t coreWrite,
	input CoreStatePkg::RegWrite_t debugWrite // Preload path, used while idle
);

logic [31:0] regs [32];
CoreStatePkg::RegWrite_t selWrite;

// Core write wins over the debug port
assign selWrite = coreWrite.enable ? coreWrite : debugWrite;

always_ff @(posedge clock)
begin
	if (!rstN)
	begin
		for (int i = 0; i < 32; i++)
			regs[i] <= 32'd0;
	end
	else if (selWrite.enable && (selWrite.index != 5'd0)) // x0 never written
		regs[selWrite.index] <= selWrite.data;
end

assign rs1Value = (rs1Index == 5'd0) ? 32'd0 : regs[rs1Index];
assign rs2Value = (rs2Index == 5'd0) ? 32'd0 : regs[rs2Index];

// Decoder drops rd = x0, so the core side should never try it
coreWriteNotX0: assert property (@(posedge clock) disable iff (!rstN)
	coreWrite.enable |-> coreWrite.index != 5'd0);

endmodule

`default_nettype wire

//--- hw/RetireCounter.sv
`timescale 1ns/1ps
`default_nettype none

module RetireCounter
#(
	parameter int CountWidth = 32
)
(
	input logic clock,
	input logic rstN,

	input logic retire,
	input logic taken,

	output logic [CountWidth - 1:0] retireCount,
	output logic [CountWidth - 1:0] redirectCount
);

// Both wrap silently at the top
always_ff @(posedge clock)
begin
	if (!rstN)
	begin
		retireCount <= '0;
		redirectCount <= '0;
	end
	else if (retire)
	begin
		retireCount <= retireCount + 1'b1;
		if (taken)
			redirectCount <= redirectCount + 1'b1; // PC left the sequential path
	end
end

endmodule

`default_nettype wire

//--- hw/CoreControl.sv
`timescale 1ns/1ps
`default_nettype none

module CoreControl
#(
	parameter logic [31:0] ResetVector = 32'd0
)
(
	input logic clock,
	input logic rstN,
	input logic instrValid,
	input logic [31:0] instruction,

	input JZJCoreFTypes::DecodedInstr_t decoded,
	output logic [31:0] rawInstruction,

	input logic [31:0] rs1Value,
	input logic [31:0] rs2Value,
	output logic [4:0] rs1Index,
	output logic [4:0] rs2Index,

	output JZJCoreFTypes::BranchALUMode_t branchALUMode,
	output JZJCoreFTypes::Funct3_t funct3,
	output logic [31:0] immediateJ,
	output logic [31:0] immediateI,
	output logic [31:0] immediateB,
	output logic [31:0] rs1,
	output logic [31:0] rs2,
	output logic [31:0] pcOfInstruction,
	input logic [31:0] programCounterInput,
	input logic [31:0] branchALUOutput,
	input logic branchTaken,

	output CoreStatePkg::RegWrite_t coreWrite,

	output logic ready,
	output logic retire,
	output CoreStatePkg::RetireRecord_t retireRecord,
	output logic taken,
	output logic [31:0] pc
);

CoreStatePkg::CoreState_t state;
JZJCoreFTypes::DecodedInstr_t decodedReg;
logic [31:0] rs1Reg;
logic [31:0] rs2Reg;
logic [31:0] nextPcReg;
logic [31:0] linkReg;
logic [31:0] pcPlus4;

// Control state
always_ff @(posedge clock)
begin
	if (!rstN)
	begin
		state <= CoreStatePkg::IDLE;
		pc <= ResetVector;
	end
	else
	begin
		unique case (state)
			CoreStatePkg::IDLE: if (instrValid) state <= CoreStatePkg::DECODE;
			CoreStatePkg::DECODE: state <= CoreStatePkg::EXECUTE;
			CoreStatePkg::EXECUTE: state <= CoreStatePkg::RETIRE;
			CoreStatePkg::RETIRE:
			begin
				state <= CoreStatePkg::IDLE;
				pc <= nextPcReg; // PC moves as the instruction retires
			end
		endcase
	end
end

// Payload pipeline, each stage loads in its own state
always_ff @(posedge clock)
begin
	if ((state == CoreStatePkg::IDLE) && instrValid)
		rawInstruction <= instruction;
	if (state == CoreStatePkg::DECODE)
	begin
		decodedReg <= decoded;
		rs1Reg <= rs1Value; // Read ports follow the live decode
		rs2Reg <= rs2Value;
	end
	if (state == CoreStatePkg::EXECUTE)
	begin
		nextPcReg <= programCounterInput;
		linkReg <= branchALUOutput;
	end
end

assign rs1Index = decoded.rs1Index;
assign rs2Index = decoded.rs2Index;

// BranchALU sees only registered operands
assign branchALUMode = decodedReg.branchALUMode;
assign funct3 = decodedReg.funct3;
assign immediateJ = decodedReg.immediateJ;
assign immediateI = decodedReg.immediateI;
assign immediateB = decodedReg.immediateB;
assign rs1 = rs1Reg;
assign rs2 = rs2Reg;
assign pcOfInstruction = pc;

assign ready = state == CoreStatePkg::IDLE;
assign retire = state == CoreStatePkg::RETIRE;

assign pcPlus4 = pc + 32'd4;
assign taken = nextPcReg != pcPlus4; // Any non-sequential next PC

assign coreWrite.enable = retire && decodedReg.writesRd;
assign coreWrite.index = decodedReg.rdIndex;
assign coreWrite.data = linkReg;

always_comb
begin
	retireRecord.pc = pc;
	retireRecord.nextPc = nextPcReg;
	retireRecord.rdIndex = decodedReg.rdIndex;
	retireRecord.rdValue = decodedReg.writesRd ? linkReg : 32'd0;
	retireRecord.rdWritten = decodedReg.writesRd;
	retireRecord.taken = taken;
	retireRecord.illegal = decodedReg.illegal;
end

retirePulse: assert property (@(posedge clock) disable iff (!rstN)
	retire |=> !retire && ready);

readyOnlyIdle: assert property (@(posedge clock) disable iff (!rstN)
	ready |-> state == CoreStatePkg::IDLE);

// ALU result gets latched at the end of EXECUTE
aluModeKnown: assert property (@(posedge clock) disable iff (!rstN)
	(state == CoreStatePkg::EXECUTE) |-> !$isunknown(branchALUMode));

endmodule

`default_nettype wire

//--- hw/ControlFlowCore.sv
`timescale 1ns/1ps
`default_nettype none

module ControlFlowCore
#(
	parameter logic [31:0] ResetVector = 32'd0,
	parameter int CountWidth = 32
)
(
	input logic clock,
	input logic rstN,
	input logic instrValid, // One-cycle strobe
	input logic [31:0] instruction,
	input CoreStatePkg::RegWrite_t debugWrite,
	output logic ready,
	output logic retire,
	output CoreStatePkg::RetireRecord_t retireRecord,
	output logic [31:0] pc,
	output logic [CountWidth - 1:0] retireCount,
	output logic [CountWidth - 1:0] redirectCount
);

JZJCoreFTypes::DecodedInstr_t decoded;
logic [31:0] rawInstruction;
logic [4:0] rs1Index;
logic [4:0] rs2Index;
logic [31:0] rs1Value;
logic [31:0] rs2Value;
JZJCoreFTypes::BranchALUMode_t branchALUMode;
JZJCoreFTypes::Funct3_t funct3;
logic [31:0] immediateJ;
logic [31:0] immediateI;
logic [31:0] immediateB;
logic [31:0] rs1;
logic [31:0] rs2;
logic [31:0] pcOfInstruction;
logic [31:0] programCounterInput;
logic [31:0] branchALUOutput;
logic branchTaken;
CoreStatePkg::RegWrite_t coreWrite;
logic taken;

InstructionDecoder u_InstructionDecoder (.instruction(rawInstruction), .decoded(decoded));

BranchALU u_BranchALU (.*);

RegisterFile u_RegisterFile (.*);

RetireCounter #(.CountWidth(CountWidth)) u_RetireCounter (.*);

CoreControl #(.ResetVector(ResetVector)) u_CoreControl (.*);

endmodule

`default_nettype wire

//--- dv/ClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module ClockGen
#(
	parameter real Period = 4.0,
	parameter int ResetCycles = 10
)
(
	output logic clock,
	output logic rstN
);

initial
begin
	clock = 1'b0;
	forever #(Period / 2) clock = ~clock; // Free running
end

initial
begin
	rstN = 1'b0;
	repeat (ResetCycles) @(posedge clock);
	@(negedge clock);
	rstN = 1'b1; // Released between active edges
end

endmodule

`default_nettype wire

//--- dv/ControlFlowCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module ControlFlowCoreTb;

localparam logic [31:0] ResetVector = 32'h0000_1000;
localparam int CountWidth = 32;

logic clock;
logic rstN;
logic instrValid;
logic [31:0] instruction;
CoreStatePkg::RegWrite_t debugWrite;
logic ready;
logic retire;
CoreStatePkg::RetireRecord_t retireRecord;
logic [31:0] pc;
logic [CountWidth - 1:0] retireCount;
logic [CountWidth - 1:0] redirectCount;

// Architectural model of the slice
logic [31:0] modelRegs [32];
logic [31:0] modelPc;
int modelRetired;
int modelRedirects;
logic [31:0] rngState;

// Outstanding instructions, oldest first
CoreStatePkg::RetireRecord_t expQ [$];
int issueCycleQ [$];
string nameQ [$];

int cycleCount = 0;
int issuedCount = 0;
int errorCount = 0;
int checksDone = 0;
int testErrors = 0;
int seenRetired = 0;
int seenRedirects = 0;

ClockGen u_ClockGen (.clock(clock), .rstN(rstN));

ControlFlowCore #(.ResetVector(ResetVector), .CountWidth(CountWidth)) u_ControlFlowCore (.*);

function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

function automatic logic [31:0] nextRandom();
	rngState = xorshift(rngState);
	return rngState;
endfunction

// Encoders for the three formats
function automatic logic [31:0] encodeJal(input logic [4:0] rd, input logic [20:0] imm);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

function automatic logic [31:0] encodeJalr(input logic [4:0] rd, input logic [4:0] rs1,
	input logic [11:0] imm, input logic [2:0] f3);
	return {imm, rs1, f3, rd, 7'b1100111};
endfunction

function automatic logic [31:0] encodeBranch(input logic [2:0] f3, input logic [4:0] rs1,
	input logic [4:0] rs2, input logic [12:0] imm);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

// Expected retire record of one instruction
function automatic CoreStatePkg::RetireRecord_t predict(input logic [31:0] instr,
	input logic [31:0] curPc, input logic [31:0] regs [32]);
	CoreStatePkg::RetireRecord_t rec;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] link;
	logic [31:0] immJ;
	logic [31:0] immI;
	logic [31:0] immB;
	logic cond;
	a = regs[instr[19:15]];
	b = regs[instr[24:20]];
	link = curPc + 32'd4;
	immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
	immI = {{20{instr[31]}}, instr[31:20]};
	immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	cond = 1'b0;
	rec = '0;
	rec.pc = curPc;
	rec.nextPc = link; // Illegal and untaken fall through
	rec.rdIndex = instr[11:7];
	case (instr[6:0])
		JZJCoreFTypes::JALOP:
		begin
			rec.nextPc = curPc + immJ;
			rec.rdWritten = instr[11:7] != 5'd0;
		end
		JZJCoreFTypes::JALROP:
		begin
			if (instr[14:12] != 3'b000)
				rec.illegal = 1'b1;
			else
			begin
				rec.nextPc = (a + immI) & ~32'd1; // Low bit dropped
				rec.rdWritten = instr[11:7] != 5'd0;
			end
		end
		JZJCoreFTypes::BRANCHOP:
		begin
			case (instr[14:12])
				3'b000: cond = a == b;
				3'b001: cond = a != b;
				3'b100: cond = $signed(a) < $signed(b);
				3'b101: cond = $signed(a) >= $signed(b);
				3'b110: cond = a < b;
				3'b111: cond = a >= b;
				default: rec.illegal = 1'b1; // 010 and 011
			endcase
			if (cond)
				rec.nextPc = curPc + immB;
		end
		default: rec.illegal = 1'b1;
	endcase
	if (rec.rdWritten)
		rec.rdValue = link;
	rec.taken = rec.nextPc != link;
	return rec;
endfunction

task automatic checkRecord(input string name, input CoreStatePkg::RetireRecord_t expected,
	input CoreStatePkg::RetireRecord_t actual);
	checksDone++;
	if (actual !== expected)
	begin
		errorCount++;
		$display("FAILED %s: expected pc=%h next=%h rd=x%0d/%h w%b t%b i%b, %s%h %s%h %s%0d/%h w%b t%b i%b",
			name, expected.pc, expected.nextPc, expected.rdIndex, expected.rdValue,
			expected.rdWritten, expected.taken, expected.illegal,
			"actual pc=", actual.pc, "next=", actual.nextPc, "rd=x", actual.rdIndex,
			actual.rdValue, actual.rdWritten, actual.taken, actual.illegal);
	end
endtask

task automatic checkPc(input string name, input logic [31:0] expected, input logic [31:0] actual);
	checksDone++;
	if (actual !== expected)
	begin
		errorCount++;
		$display("FAILED %s: expected pc %h, actual %h", name, expected, actual);
	end
endtask

task automatic checkCounter(input string name, input logic [CountWidth - 1:0] expected,
	input logic [CountWidth - 1:0] actual);
	checksDone++;
	if (actual !== expected)
	begin
		errorCount++;
		$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
	end
endtask

task automatic reportProblem(input string msg);
	errorCount++;
	$display("ERROR: %s", msg);
endtask

task automatic endTest(input string name);
	$display("test %-10s done, %0d errors", name, errorCount - testErrors);
	testErrors = errorCount;
endtask

// Register preload through the debug port, only while idle
task automatic preload(input logic [4:0] index, input logic [31:0] value);
	@(negedge clock);
	while (!ready)
		@(negedge clock);
	debugWrite = {1'b1, index, value};
	@(negedge clock);
	debugWrite = '0;
	if (index != 5'd0)
		modelRegs[index] = value;
endtask

// One instruction, optionally with a strobe held through the busy cycles
task automatic issue(input string name, input logic [31:0] instr, input bit stray);
	CoreStatePkg::RetireRecord_t exp;
	@(negedge clock);
	while (!ready)
		@(negedge clock);
	exp = predict(instr, modelPc, modelRegs);
	expQ.push_back(exp);
	issueCycleQ.push_back(cycleCount);
	nameQ.push_back(name);
	issuedCount++;
	if (exp.rdWritten)
		modelRegs[exp.rdIndex] = exp.rdValue;
	modelPc = exp.nextPc;
	modelRetired++;
	if (exp.taken)
		modelRedirects++;
	instrValid = 1'b1;
	instruction = instr;
	@(negedge clock);
	if (stray)
	begin
		instruction = nextRandom(); // Must not be captured
		repeat (3) @(negedge clock); // DECODE, EXECUTE, RETIRE
	end
	instrValid = 1'b0;
	while (expQ.size() != 0)
		@(negedge clock);
endtask

always @(posedge clock)
begin
	cycleCount++;
	if (cycleCount > 20 * issuedCount + 200)
	begin
		$display("ERROR: timeout at cycle %0d, the core stopped retiring", cycleCount);
		$display("** FAIL **");
		$finish;
	end
end

// Compare side, sampled mid-cycle
always @(negedge clock)
begin
	if (rstN && retire)
	begin
		if (expQ.size() == 0)
			reportProblem("retire pulsed with no instruction outstanding");
		else
		begin
			if (cycleCount != issueCycleQ[0] + 3)
				reportProblem($sformatf("%s retired at cycle %0d, not three cycles after capture",
					nameQ[0], cycleCount));
			checkRecord(nameQ[0], expQ[0], retireRecord);
			checkPc({nameQ[0], " pc"}, expQ[0].pc, pc);
			checkCounter({nameQ[0], " retireCount"}, seenRetired, retireCount); // Old value
			checkCounter({nameQ[0], " redirectCount"}, seenRedirects, redirectCount);
			seenRetired++;
			if (expQ[0].taken)
				seenRedirects++;
			void'(expQ.pop_front());
			void'(issueCycleQ.pop_front());
			void'(nameQ.pop_front());
		end
	end
end

initial
begin
	logic [31:0] r;
	logic [31:0] r2;
	logic [31:0] mixInstr;
	logic [4:0] rd;
	logic [4:0] rs;
	logic [31:0] opA [5];
	logic [31:0] opB [5];
	logic [2:0] f3Vals [6];
	instrValid = 1'b0;
	instruction = 32'd0;
	debugWrite = '0;
	rngState = 32'h48cb_7518;
	modelPc = ResetVector;
	modelRetired = 0;
	modelRedirects = 0;
	for (int i = 0; i < 32; i++)
		modelRegs[i] = 32'd0;
	f3Vals = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
	opA = '{32'd0, 32'h1234_5678, 32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff};
	opB = '{32'd0, 32'h1234_5678, 32'h7fff_ffff, 32'h8000_0000, 32'h0000_0000};
	@(posedge rstN);
	@(negedge clock);

	checkPc("reset pc", ResetVector, pc);
	checkCounter("reset retireCount", 0, retireCount);
	checkCounter("reset redirectCount", 0, redirectCount);
	if (!ready || retire)
		reportProblem("ready low or retire high after reset");
	endTest("reset");

	for (int i = 0; i < 6; i++)
	begin
		r = nextRandom();
		rd = r[4:0]; // x0 allowed
		issue($sformatf("jal %0d", i), encodeJal(rd, {r[25:6], 1'b0}), 1'b0);
		rs = r[30:26] | 5'd1;
		preload(rs, nextRandom());
		r2 = nextRandom();
		issue($sformatf("jalr %0d", i), encodeJalr(r2[4:0], rs, r2[16:5], 3'b000), 1'b0);
		if (rd != 5'd0)
			issue($sformatf("link readback %0d", i), encodeJalr(5'd0, rd, 12'd0, 3'b000), 1'b0);
	end
	issue("jal to x0", encodeJal(5'd0, 21'h000800), 1'b0);
	issue("x0 readback", encodeJalr(5'd3, 5'd0, 12'h124, 3'b000), 1'b0);
	preload(5'd9, 32'h0000_2000);
	issue("jalr odd target", encodeJalr(5'd9, 5'd9, 12'h001, 3'b000), 1'b0); // rd == rs1
	endTest("jump");

	for (int f = 0; f < 6; f++)
	begin
		for (int p = 0; p < 5; p++)
		begin
			if (p == 0)
			begin
				opA[0] = nextRandom();
				opB[0] = nextRandom();
			end
			preload(5'd1, opA[p]);
			preload(5'd2, opB[p]);
			r = nextRandom();
			issue($sformatf("branch %b pair %0d", f3Vals[f], p),
				encodeBranch(f3Vals[f], 5'd1, 5'd2, {r[11:0], 1'b0}), 1'b0);
		end
	end
	endTest("branch");

	preload(5'd7, 32'h0000_3000); // Sentinel, must survive
	for (int i = 0; i < 4; i++)
	begin
		do
			r = nextRandom();
		while (r[6:0] == JZJCoreFTypes::JALOP || r[6:0] == JZJCoreFTypes::JALROP ||
			r[6:0] == JZJCoreFTypes::BRANCHOP);
		issue($sformatf("bad opcode %0d", i), {r[31:12], 5'd7, r[6:0]}, 1'b0);
	end
	for (int f = 1; f < 8; f++)
		issue($sformatf("jalr funct3 %0d", f), encodeJalr(5'd7, 5'd1, 12'h010, f[2:0]), 1'b0);
	issue("branch funct3 010", encodeBranch(3'b010, 5'd1, 5'd2, 13'h0040), 1'b0);
	issue("branch funct3 011", encodeBranch(3'b011, 5'd1, 5'd2, 13'h0040), 1'b0);
	issue("sentinel readback", encodeJalr(5'd0, 5'd7, 12'd0, 3'b000), 1'b0);
	endTest("illegal");

	for (int i = 0; i < 4; i++)
	begin
		r = nextRandom();
		issue($sformatf("stray strobe %0d", i), encodeJal(r[4:0], {r[25:6], 1'b0}), 1'b1);
	end
	endTest("timing");

	for (int i = 0; i < 40; i++)
	begin
		r = nextRandom();
		r2 = nextRandom();
		case (r[1:0])
			2'd0: mixInstr = encodeJal(r2[4:0], {r2[25:6], 1'b0});
			2'd1: mixInstr = encodeJalr(r2[4:0], r2[9:5], r2[21:10],
				r2[31] ? r2[24:22] : 3'b000);
			2'd2: mixInstr = encodeBranch(r2[2:0], r2[7:3], r2[12:8], {r2[24:13], 1'b0});
			default: mixInstr = r2; // Mostly illegal
		endcase
		issue($sformatf("mix %0d", i), mixInstr, 1'b0);
	end
	@(negedge clock); // Counters move one edge after retire
	checkCounter("final retireCount", modelRetired, retireCount);
	checkCounter("final redirectCount", modelRedirects, redirectCount);
	checkPc("final pc", modelPc, pc);
	endTest("mix");

	$display("%0d instructions, %0d checks, %0d errors", issuedCount, checksDone, errorCount);
	if (errorCount == 0)
		$display("** PASS **");
	else
		$display("** FAIL **");
	$finish;
end

endmodule

`default_nettype wire

//--- build.f
hw/JZJCoreFTypes.sv
hw/CoreStatePkg.sv
hw/InstructionDecoder.sv
hw/BranchALU.sv
hw/RegisterFile.sv
hw/RetireCounter.sv
hw/CoreControl.sv
hw/ControlFlowCore.sv
dv/ClockGen.sv
dv/ControlFlowCoreTb.sv

//--- Bender.yml
package:
  name: control_flow_core

sources:
  - hw/JZJCoreFTypes.sv
  - hw/CoreStatePkg.sv
  - hw/InstructionDecoder.sv
  - hw/BranchALU.sv
  - hw/RegisterFile.sv
  - hw/RetireCounter.sv
  - hw/CoreControl.sv
  - hw/ControlFlowCore.sv
  - target: simulation
    files:
      - dv/ClockGen.sv
      - dv/ControlFlowCoreTb.sv
